//--- hdl/plic_pkg.sv
// Shared widths, register-select and gateway-state enums, Wishbone and candidate structs

package plic_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Source id, 0 reserved for no interrupt
  localparam int SRC_ID_W = 5;
  // Priority and threshold levels 0..7
  localparam int PRIO_W   = 3;
  // Wishbone byte address and data
  localparam int WB_ADR_W = 8;
  localparam int WB_DAT_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  // Address decode result
  typedef enum logic [2:0] {
    REG_PRIO,
    REG_PENDING,
    REG_ENABLE,
    REG_TRIGGER,
    REG_THRESHOLD,
    REG_CLAIM,
    REG_NONE
  } reg_sel_e;

  // Gateway request life cycle
  typedef enum logic [1:0] {
    GW_IDLE,
    GW_PENDING,
    GW_CLAIMED
  } gw_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // Master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // Candidate passed between pipeline stages
  typedef struct packed {
    logic                valid;
    logic [SRC_ID_W-1:0] id;
    logic [PRIO_W-1:0]   prio;
  } cand_t;

endpackage

//--- hdl/plic_gateway.sv
// Per-source interrupt gateway with edge detect, pending counter and claim FSM
`timescale 1ns/1ps

module plic_gateway #(
  parameter int MAX_PENDING_COUNT = 4
)
(
  input  logic clk,
  input  logic rst_n,
  input  logic src,
  input  logic edge_lvl,
  input  logic claim,
  input  logic complete,
  output logic ip
);

  // Counter width, at least one bit even with no extra edges kept
  localparam int CNT_W = (MAX_PENDING_COUNT > 0) ? $clog2(MAX_PENDING_COUNT + 1) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_PENDING_COUNT);

  logic                src_dly;
  logic                src_edge;
  logic [CNT_W-1:0]    pend_cnt;
  logic                take;
  plic_pkg::gw_state_e state;
  plic_pkg::gw_state_e state_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Rising edge detect
  ////////////////////////////////////////////////////////////////////////////

  // Registered edge, adds one cycle in edge mode
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      src_dly  <= 1'b0;
      src_edge <= 1'b0;
    end
    else
    begin
      src_dly  <= src;
      src_edge <= src & ~src_dly;
    end

  // Request taken into pending this cycle
  // Edge mode uses a fresh edge or a stored one
  assign take = (state == plic_pkg::GW_IDLE) &&
                (edge_lvl ? (src_edge || (pend_cnt != '0)) : src);

  ////////////////////////////////////////////////////////////////////////////
  // Missed-edge counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      pend_cnt <= '0;
    else if (!edge_lvl)
      pend_cnt <= '0;
    // Stored edge served and no new one arriving
    else if (take && (pend_cnt != '0) && !src_edge)
      pend_cnt <= pend_cnt - 1'b1;
    // Edge while busy, saturate at max
    else if (!take && src_edge && (pend_cnt < CNT_MAX))
      pend_cnt <= pend_cnt + 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Pending / claimed FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      plic_pkg::GW_IDLE:
        if (take)
          state_nxt = plic_pkg::GW_PENDING;
      plic_pkg::GW_PENDING:
        if (claim)
          state_nxt = plic_pkg::GW_CLAIMED;
      // Source blocked until handler completes
      plic_pkg::GW_CLAIMED:
        if (complete)
          state_nxt = plic_pkg::GW_IDLE;
      default:
        state_nxt = plic_pkg::GW_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      state <= plic_pkg::GW_IDLE;
    else
      state <= state_nxt;

  // Pending only while waiting for a claim
  assign ip = (state == plic_pkg::GW_PENDING);

endmodule

//--- hdl/plic_select.sv
// Registered stage picking the highest-priority enabled pending source
`timescale 1ns/1ps

module plic_select #(
  parameter int SOURCES = 8
)
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [SOURCES:1]                       ip,
  input  logic [SOURCES:1]                       enable,
  input  logic [SOURCES:1][plic_pkg::PRIO_W-1:0] prio,
  output plic_pkg::cand_t                        best
);

  localparam int ID_W = plic_pkg::SRC_ID_W;

  // Combinational winner
  plic_pkg::cand_t scan;

  ////////////////////////////////////////////////////////////////////////////
  // Priority scan
  ////////////////////////////////////////////////////////////////////////////

  // Start from prio 0 so a zero priority never wins
  // Strict compare keeps the lowest id on ties
  always_comb
  begin
    scan = '0;
    for (int i = 1; i <= SOURCES; i++)
    begin
      if (ip[i] && enable[i] && (prio[i] > scan.prio))
      begin
        scan.valid = 1'b1;
        scan.id    = ID_W'(i);
        scan.prio  = prio[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // One cycle from ip, enable or prio
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      best <= '0;
    else
      best <= scan;

endmodule

//--- hdl/plic_target.sv
// Registered threshold stage driving irq and the claimable candidate
`timescale 1ns/1ps

module plic_target
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  plic_pkg::cand_t             best,
  input  logic [plic_pkg::PRIO_W-1:0] threshold,
  output logic                        irq,
  output plic_pkg::cand_t             claim_cand
);

  // Candidate clears the threshold
  logic above;

  ////////////////////////////////////////////////////////////////////////////
  // Threshold compare
  ////////////////////////////////////////////////////////////////////////////

  // Strictly above, so threshold 7 masks everything
  assign above = best.valid && (best.prio > threshold);

  // Id and priority follow best unconditionally
  // Only valid carries the threshold decision
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
      claim_cand <= '0;
    else
    begin
      claim_cand.valid <= above;
      claim_cand.id    <= best.id;
      claim_cand.prio  <= best.prio;
    end

  // Single target, irq is the held valid
  assign irq = claim_cand.valid;

endmodule

//--- hdl/plic_wb_regs.sv
// Wishbone classic register slave with claim and complete strobe generation
`timescale 1ns/1ps

module plic_wb_regs #(
  parameter int SOURCES = 8
)
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  plic_pkg::wb_req_t                      wb_req,
  output plic_pkg::wb_rsp_t                      wb_rsp,
  input  logic [SOURCES:1]                       ip,
  input  plic_pkg::cand_t                        claim_cand,
  output logic [SOURCES:1]                       enable,
  output logic [SOURCES:1]                       edge_lvl,
  output logic [SOURCES:1][plic_pkg::PRIO_W-1:0] prio,
  output logic [plic_pkg::PRIO_W-1:0]            threshold,
  output logic [SOURCES:1]                       claim,
  output logic [SOURCES:1]                       complete
);

  localparam int ID_W   = plic_pkg::SRC_ID_W;
  localparam int PRIO_W = plic_pkg::PRIO_W;
  localparam int ADR_W  = plic_pkg::WB_ADR_W;
  localparam int DAT_W  = plic_pkg::WB_DAT_W;

  // Fixed register addresses
  localparam logic [ADR_W-1:0] ADR_PENDING   = 'h80;
  localparam logic [ADR_W-1:0] ADR_ENABLE    = 'h84;
  localparam logic [ADR_W-1:0] ADR_TRIGGER   = 'h88;
  localparam logic [ADR_W-1:0] ADR_THRESHOLD = 'h8C;
  localparam logic [ADR_W-1:0] ADR_CLAIM     = 'h90;

  logic               access;
  logic               ack_q;
  logic [DAT_W-1:0]   rd_data;
  logic [DAT_W-1:0]   rd_q;
  plic_pkg::reg_sel_e sel;
  logic [ID_W-1:0]    prio_idx;
  logic [ID_W-1:0]    claim_id;
  logic [SOURCES:1]   claim_hot;
  logic [SOURCES:1]   complete_hot;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Accepted request, ~ack forces a low cycle between acks
  assign access   = wb_req.cyc & wb_req.stb & ~ack_q;
  // Word index below 0x80 is the source id
  assign prio_idx = wb_req.adr[ID_W+1:2];

  always_comb
  begin
    sel = plic_pkg::REG_NONE;
    if (!wb_req.adr[ADR_W-1] && (wb_req.adr[1:0] == 2'b00) &&
        (prio_idx != '0) && (prio_idx <= SOURCES))
      sel = plic_pkg::REG_PRIO;
    else
      case (wb_req.adr)
        ADR_PENDING:   sel = plic_pkg::REG_PENDING;
        ADR_ENABLE:    sel = plic_pkg::REG_ENABLE;
        ADR_TRIGGER:   sel = plic_pkg::REG_TRIGGER;
        ADR_THRESHOLD: sel = plic_pkg::REG_THRESHOLD;
        ADR_CLAIM:     sel = plic_pkg::REG_CLAIM;
        default:       sel = plic_pkg::REG_NONE;
      endcase
  end

  // Claim returns 0 when nothing clears the threshold
  assign claim_id = claim_cand.valid ? claim_cand.id : '0;

  // One-hot strobes, full word compare rejects ids out of range
  always_comb
  begin
    for (int k = 1; k <= SOURCES; k++)
    begin
      claim_hot[k]    = (claim_id == ID_W'(k));
      complete_hot[k] = (wb_req.dat == DAT_W'(k));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 of vector registers stays 0
  always_comb
  begin
    rd_data = '0;
    case (sel)
      plic_pkg::REG_PRIO:      rd_data[PRIO_W-1:0] = prio[prio_idx];
      plic_pkg::REG_PENDING:   rd_data[SOURCES:1]  = ip;
      plic_pkg::REG_ENABLE:    rd_data[SOURCES:1]  = enable;
      plic_pkg::REG_TRIGGER:   rd_data[SOURCES:1]  = edge_lvl;
      plic_pkg::REG_THRESHOLD: rd_data[PRIO_W-1:0] = threshold;
      plic_pkg::REG_CLAIM:     rd_data[ID_W-1:0]   = claim_id;
      default:                 rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  // Pending and unmapped writes fall through
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      prio      <= '0;
      enable    <= '0;
      edge_lvl  <= '0;
      threshold <= '0;
    end
    else if (access && wb_req.we)
    begin
      case (sel)
        plic_pkg::REG_PRIO:      prio[prio_idx] <= wb_req.dat[PRIO_W-1:0];
        plic_pkg::REG_ENABLE:    enable         <= wb_req.dat[SOURCES:1];
        plic_pkg::REG_TRIGGER:   edge_lvl       <= wb_req.dat[SOURCES:1];
        plic_pkg::REG_THRESHOLD: threshold      <= wb_req.dat[PRIO_W-1:0];
        default:                 ;
      endcase
    end

  ////////////////////////////////////////////////////////////////////////////
  // Ack and strobes
  ////////////////////////////////////////////////////////////////////////////

  // Strobes line up with ack
  always_ff @(posedge clk or negedge rst_n)
    if (!rst_n)
    begin
      ack_q    <= 1'b0;
      claim    <= '0;
      complete <= '0;
    end
    else
    begin
      ack_q    <= access;
      claim    <= (access && !wb_req.we && (sel == plic_pkg::REG_CLAIM)) ? claim_hot : '0;
      complete <= (access && wb_req.we && (sel == plic_pkg::REG_CLAIM)) ? complete_hot : '0;
    end

  // Read data captured with the request, valid during ack
  always_ff @(posedge clk)
    if (access)
      rd_q <= rd_data;

  always_comb
  begin
    wb_rsp.ack = ack_q;
    wb_rsp.dat = rd_q;
  end

endmodule

//--- hdl/plic_top.sv
// PLIC top level with gateway array, select and target stages and register slave
`timescale 1ns/1ps

module plic_top #(
  parameter int SOURCES           = 8,
  parameter int MAX_PENDING_COUNT = 4
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [SOURCES:1]  src,
  input  plic_pkg::wb_req_t wb_req,
  output plic_pkg::wb_rsp_t wb_rsp,
  output logic              irq
);

  // Gateway side
  logic [SOURCES:1]                       ip;
  logic [SOURCES:1]                       edge_lvl;
  logic [SOURCES:1]                       claim;
  logic [SOURCES:1]                       complete;
  // Software configuration
  logic [SOURCES:1]                       enable;
  logic [SOURCES:1][plic_pkg::PRIO_W-1:0] prio;
  logic [plic_pkg::PRIO_W-1:0]            threshold;
  // Pipeline candidates
  plic_pkg::cand_t                        best;
  plic_pkg::cand_t                        claim_cand;

  ////////////////////////////////////////////////////////////////////////////
  // Gateways, one per source id
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar k = 1; k <= SOURCES; k++)
    begin : g_gw
      plic_gateway #(
        .MAX_PENDING_COUNT (MAX_PENDING_COUNT)
      ) i_gateway (
        .clk      (clk),
        .rst_n    (rst_n),
        .src      (src[k]),
        .edge_lvl (edge_lvl[k]),
        .claim    (claim[k]),
        .complete (complete[k]),
        .ip       (ip[k])
      );
    end
  endgenerate

  // Highest enabled pending source
  plic_select #(
    .SOURCES (SOURCES)
  ) i_select (
    .clk    (clk),
    .rst_n  (rst_n),
    .ip     (ip),
    .enable (enable),
    .prio   (prio),
    .best   (best)
  );

  // Threshold and irq
  plic_target i_target (
    .clk        (clk),
    .rst_n      (rst_n),
    .best       (best),
    .threshold  (threshold),
    .irq        (irq),
    .claim_cand (claim_cand)
  );

  // Register slave beside the pipeline
  plic_wb_regs #(
    .SOURCES (SOURCES)
  ) i_wb_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .ip         (ip),
    .claim_cand (claim_cand),
    .enable     (enable),
    .edge_lvl   (edge_lvl),
    .prio       (prio),
    .threshold  (threshold),
    .claim      (claim),
    .complete   (complete)
  );

endmodule

//--- verif/plic_tb.sv
// PLIC testbench with clock, reset, Wishbone tasks, LCG and checks for all tests
`timescale 1ns/1ps

module plic_tb;

  localparam int SOURCES   = 8;
  localparam int MAX_PEND  = 4;
  localparam int TIMEOUT   = 200;
  // Register addresses
  localparam logic [7:0] ADR_PENDING   = 8'h80;
  localparam logic [7:0] ADR_ENABLE    = 8'h84;
  localparam logic [7:0] ADR_TRIGGER   = 8'h88;
  localparam logic [7:0] ADR_THRESHOLD = 8'h8C;
  localparam logic [7:0] ADR_CLAIM     = 8'h90;
  // Bits 1..SOURCES of a vector register
  localparam logic [31:0] VEC_MASK = ((32'h1 << (SOURCES + 1)) - 1) & ~32'h1;

  logic              clk;
  logic              rst_n;
  logic [SOURCES:1]  src;
  plic_pkg::wb_req_t wb_req;
  plic_pkg::wb_rsp_t wb_rsp;
  logic              irq;

  logic [31:0] lcg_state;
  int          test_errs;
  int          tests_passed;
  int          tests_failed;

  plic_top #(
    .SOURCES           (SOURCES),
    .MAX_PENDING_COUNT (MAX_PEND)
  ) i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .src    (src),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .irq    (irq)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0)
    begin
      tests_passed++;
      $display("Test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master, driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    int n;
    n = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    // First edge skipped, ack may still be high from a previous access
    @(negedge clk);
    while (!wb_rsp.ack && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!wb_rsp.ack)
      stop_on_timeout("Wishbone ack on a write");
    else
      wb_req = '0;
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    int n;
    n = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    @(negedge clk);
    while (!wb_rsp.ack && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!wb_rsp.ack)
      stop_on_timeout("Wishbone ack on a read");
    else
    begin
      dat    = wb_rsp.dat;
      wb_req = '0;
    end
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq !== level && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (irq !== level)
      stop_on_timeout($sformatf("irq to become %0b", level));
  endtask

  // Polls the pending register
  task automatic wait_pending(input int id);
    logic [31:0] rd;
    int          n;
    n = 0;
    wb_read(ADR_PENDING, rd);
    while (!rd[id] && n < TIMEOUT)
    begin
      wb_read(ADR_PENDING, rd);
      n++;
    end
    if (!rd[id])
      stop_on_timeout($sformatf("pending bit %0d", id));
  endtask

  task automatic claim_expect(input string what, input int exp);
    logic [31:0] rd;
    wb_read(ADR_CLAIM, rd);
    check_value(what, rd, exp);
  endtask

  // Back to reset values
  task automatic clear_config();
    for (int k = 1; k <= SOURCES; k++)
      wb_write(8'(4 * k), 32'h0);
    wb_write(ADR_ENABLE, 32'h0);
    wb_write(ADR_TRIGGER, 32'h0);
    wb_write(ADR_THRESHOLD, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_readback();
    logic [31:0] vals [1:SOURCES];
    logic [31:0] v;
    logic [31:0] rd;
    check_value("irq after reset", irq, 0);
    check_value("ack after reset", wb_rsp.ack, 0);
    for (int k = 1; k <= SOURCES; k++)
    begin
      vals[k] = lcg_next();
      wb_write(8'(4 * k), vals[k]);
    end
    // Only 3 priority bits kept
    for (int k = 1; k <= SOURCES; k++)
    begin
      wb_read(8'(4 * k), rd);
      check_value($sformatf("priority %0d", k), rd, vals[k] & 32'h7);
    end
    // Bit 0 forced set in the write, reads 0
    v = lcg_next() | 32'h1;
    wb_write(ADR_ENABLE, v);
    wb_read(ADR_ENABLE, rd);
    check_value("enable", rd, v & VEC_MASK);
    v = lcg_next() | 32'h1;
    wb_write(ADR_TRIGGER, v);
    wb_read(ADR_TRIGGER, rd);
    check_value("trigger", rd, v & VEC_MASK);
    v = lcg_next();
    wb_write(ADR_THRESHOLD, v);
    wb_read(ADR_THRESHOLD, rd);
    check_value("threshold", rd, v & 32'h7);
    // Source 0, source past SOURCES and a gap address
    wb_write(8'h00, lcg_next());
    wb_read(8'h00, rd);
    check_value("priority 0", rd, 0);
    wb_write(8'(4 * (SOURCES + 1)), lcg_next());
    wb_read(8'(4 * (SOURCES + 1)), rd);
    check_value("unmapped priority", rd, 0);
    wb_write(8'h94, lcg_next());
    wb_read(8'h94, rd);
    check_value("unmapped 0x94", rd, 0);
    clear_config();
  endtask

  task automatic test_level();
    logic [31:0] rd;
    wb_write(8'h0C, 32'd5);
    wb_write(ADR_ENABLE, 32'h1 << 3);
    src[3] = 1'b1;
    wait_irq(1'b1);
    wb_read(ADR_PENDING, rd);
    check_value("pending bit 3", rd[3], 1);
    claim_expect("claim level", 3);
    wait_irq(1'b0);
    wb_read(ADR_PENDING, rd);
    check_value("pending bit 3 after claim", rd[3], 0);
    // Claimed gateway blocks the held level
    repeat (10)
    begin
      @(negedge clk);
      check_value("irq while claimed", irq, 0);
    end
    wb_write(ADR_CLAIM, 32'd3);
    // Gateway back in plic_pkg::GW_IDLE, level still high so it re-pends
    wait_irq(1'b1);
    claim_expect("claim after complete", 3);
    src[3] = 1'b0;
    wb_write(ADR_CLAIM, 32'd3);
    wait_cycles(4);
    check_value("irq after release", irq, 0);
    clear_config();
  endtask

  task automatic test_arbitration();
    int               prio_val [1:SOURCES];
    logic [SOURCES:1] active;
    logic [SOURCES:1] remaining;
    int               exp_id;
    int               exp_prio;
    // Ids 1, 2, 4, 5, 7 and 8
    active    = 8'b1101_1011;
    remaining = active;
    for (int k = 1; k <= SOURCES; k++)
    begin
      prio_val[k] = ((lcg_next() >> 16) % 7) + 1;
      wb_write(8'(4 * k), 32'(prio_val[k]));
    end
    wb_write(ADR_ENABLE, VEC_MASK);
    src = active;
    wait_irq(1'b1);
    wait_cycles(3);
    while (remaining != '0)
    begin
      // Highest priority, lowest id on ties
      exp_id   = 0;
      exp_prio = 0;
      for (int k = 1; k <= SOURCES; k++)
        if (remaining[k] && prio_val[k] > exp_prio)
        begin
          exp_id   = k;
          exp_prio = prio_val[k];
        end
      claim_expect($sformatf("arbitration claim (prio %0d)", exp_prio), exp_id);
      remaining[exp_id] = 1'b0;
      src[exp_id]       = 1'b0;
      wb_write(ADR_CLAIM, 32'(exp_id));
      wait_cycles(4);
    end
    claim_expect("final claim", 0);
    check_value("irq after arbitration", irq, 0);
    clear_config();
  endtask

  task automatic test_threshold();
    logic [31:0] rd;
    wb_write(8'h08, 32'd3);
    wb_write(ADR_THRESHOLD, 32'd3);
    wb_write(ADR_ENABLE, 32'h1 << 2);
    src[2] = 1'b1;
    wait_pending(2);
    wait_cycles(4);
    // Priority equal to threshold is masked
    check_value("irq at threshold", irq, 0);
    claim_expect("claim at threshold", 0);
    wb_write(ADR_THRESHOLD, 32'd2);
    wait_irq(1'b1);
    claim_expect("claim below threshold", 2);
    wait_irq(1'b0);
    src[2] = 1'b0;
    wb_write(ADR_CLAIM, 32'd2);
    // Disabled but pending
    wb_write(ADR_ENABLE, 32'h0);
    src[2] = 1'b1;
    wait_pending(2);
    repeat (6)
    begin
      @(negedge clk);
      check_value("irq while disabled", irq, 0);
    end
    wb_read(ADR_PENDING, rd);
    check_value("pending disabled", rd & VEC_MASK, 32'h1 << 2);
    src[2] = 1'b0;
    wb_write(ADR_ENABLE, 32'h1 << 2);
    wait_irq(1'b1);
    claim_expect("claim after enable", 2);
    wb_write(ADR_CLAIM, 32'd2);
    wait_cycles(4);
    clear_config();
  endtask

  task automatic test_edge(input int pulses);
    int rounds;
    rounds = (pulses < MAX_PEND + 1) ? pulses : MAX_PEND + 1;
    wb_write(8'h18, 32'd4);
    wb_write(ADR_TRIGGER, 32'h1 << 6);
    wb_write(ADR_ENABLE, 32'h1 << 6);
    // First pulse pends, the rest are counted while pending
    repeat (pulses)
    begin
      src[6] = 1'b1;
      @(negedge clk);
      src[6] = 1'b0;
      @(negedge clk);
    end
    for (int r = 0; r < rounds; r++)
    begin
      wait_irq(1'b1);
      claim_expect($sformatf("edge round %0d", r), 6);
      wait_irq(1'b0);
      wb_write(ADR_CLAIM, 32'd6);
    end
    wait_cycles(6);
    claim_expect("claim after edge rounds", 0);
    check_value("irq after edge rounds", irq, 0);
    clear_config();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    src          = '0;
    wb_req       = '0;
    lcg_state    = 32'd41;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_readback();
    end_test("register readback");
    test_level();
    end_test("level life cycle");
    test_arbitration();
    end_test("arbitration");
    test_threshold();
    end_test("threshold and enable");
    test_edge(2);
    end_test("edge counting, 2 pulses");
    test_edge(7);
    end_test("edge counting, 7 pulses");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- project.f
hdl/plic_pkg.sv
hdl/plic_gateway.sv
hdl/plic_select.sv
hdl/plic_target.sv
hdl/plic_wb_regs.sv
hdl/plic_top.sv
verif/plic_tb.sv
